// File: compile.f
+incdir+verilog
verilog/fetch_bus_pkg.sv
verilog/fetch_core_pkg.sv
verilog/read_tag_fifo.sv
verilog/prefetch_requester.sv
verilog/fetch_word_buffer.sv
verilog/parcel_assembler.sv
verilog/pc_sequencer.sv
verilog/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fetch stage testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_tb -f compile.f -o fetch_sim

# Raise the runtime error limit so assertion failures reach the testbench summary
./obj_dir/fetch_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation passed"

// File: dv/fetch_golden.txt
# Records: M <word addr> <data> | J <after n deliveries> <target pc> | E <test> <pc> <instr>
# All fields are hex, compressed instructions are expected zero extended
M 00000000 00100093
M 00000004 00200113
M 00000008 00300193
M 0000000c 00400213
M 00000010 45854501
M 00000014 00a58633
M 00000018 86930605
M 0000001c 071300c6
M 00000020 000100d7
M 00000040 46050000
M 00000044 00b50533
M 00000048 00018082
J 0000000b 00000042
J 0000000e 00000004
E 1 00000000 00100093
E 1 00000004 00200113
E 1 00000008 00300193
E 1 0000000c 00400213
E 2 00000010 00004501
E 2 00000012 00004585
E 2 00000014 00a58633
E 2 00000018 00000605
E 3 0000001a 00c68693
E 3 0000001e 00d70713
E 3 00000022 00000001
E 4 00000042 00004605
E 4 00000044 00b50533
E 4 00000048 00008082
E 5 00000004 00200113
E 5 00000008 00300193

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

// Testbench for the fetch stage
// Memory, jumps and the expected delivery stream all come from the golden file
module fetch_tb
  import fetch_bus_pkg::*;
  import fetch_core_pkg::*;
();
  // Cycles without a delivery before the run is declared stuck
  localparam int IDLE_LIMIT = 400;

  logic        clk;
  logic        rest;
  bus_req_t    bus_req;
  logic        bus_req_ready;
  bus_rsp_t    bus_rsp;
  logic        jump_en;
  logic [31:0] jump_addr;
  fetch_out_t  deliv;
  logic        deliv_ready;

  // Golden contents
  logic [31:0] mem [logic [31:0]];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_instr [$];
  int          exp_test [$];
  int          jmp_after [$];
  logic [31:0] jmp_target [$];

  // Reads accepted by the memory model, answered in order once due
  logic [31:0] pend_addr [$];
  int          pend_due [$];

  int          cyc;
  int          n_seen;
  int          n_checks;
  int          n_errors;
  int          test_errors_base;
  int          jmp_idx;
  int          idle;
  int          stall_left;
  int unsigned seed_dummy;
  int unsigned asrt_fails;
  logic        jump_now;
  logic        timed_out;
  logic        load_ok;
  logic        bad_golden;

  fetch_top dut0 (
    .clk           (clk),
    .rest          (rest),
    .bus_req       (bus_req),
    .bus_req_ready (bus_req_ready),
    .bus_rsp       (bus_rsp),
    .jump_en       (jump_en),
    .jump_addr     (jump_addr),
    .deliv         (deliv),
    .deliv_ready   (deliv_ready)
  );

  bind fetch_top fetch_assertions u_checks (
    .clk         (clk),
    .rest        (rest),
    .bus_req     (bus_req),
    .jump_en     (jump_en),
    .deliv       (deliv),
    .deliv_ready (deliv_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    n_checks++;
    if (act_val !== exp_val) begin
      $display("FAIL %s expected %08h actual %08h", name, exp_val, act_val);
      n_errors++;
    end
  endtask

  // Words missing from the golden file read as a pattern of their full address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'hc3a5_5a3c;
  endfunction

  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    fd = $fopen("dv/fetch_golden.txt", "r");
    if (fd == 0) begin
      load_ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Blank lines and comment lines carry no record
      if (n == 0 || line.len() < 3 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h", kind, f1, f2, f3);
      case (kind)
        "M": mem[f1] = f2;
        "J": begin
          jmp_after.push_back(int'(f1));
          jmp_target.push_back(f2);
        end
        "E": begin
          exp_test.push_back(int'(f1));
          exp_pc.push_back(f2);
          exp_instr.push_back(f3);
        end
        default: load_ok = 1'b0;
      endcase
    end
    $fclose(fd);
  endtask

  // Compares one transfer with the next expected instruction
  task automatic record_delivery();
    logic [31:0] step;
    // Low bits of 3 mean a 32-bit instruction, so the sequential PC moves by 4
    step = (exp_instr[n_seen][1:0] == 2'b11) ? 32'd4 : 32'd2;
    check_value("deliv.pc", exp_pc[n_seen], deliv.pc);
    check_value("deliv.instr", exp_instr[n_seen], deliv.instr);
    check_value("deliv.next_pc", exp_pc[n_seen] + step, deliv.next_pc);
    n_seen++;
    if (n_seen == exp_pc.size() || exp_test[n_seen] != exp_test[n_seen-1]) begin
      $display("test %0d done: %0d errors", exp_test[n_seen-1], n_errors - test_errors_base);
      test_errors_base = n_errors;
    end
    // The jump goes out right after the recorded number of deliveries
    if (jmp_idx < jmp_after.size() && jmp_after[jmp_idx] == n_seen) begin
      jump_now = 1'b1;
    end
  endtask

  // Looks at the stable values in the middle of a cycle
  task automatic observe_cycle();
    if (bus_req.valid && bus_req_ready) begin
      pend_addr.push_back(bus_req.addr);
      pend_due.push_back(cyc + 1 + int'($urandom % 4));
    end
    if (deliv.valid && deliv_ready) begin
      record_delivery();
      idle = 0;
    end else begin
      idle++;
    end
  endtask

  // Sets the inputs for the cycle that starts at this edge
  task automatic drive_cycle();
    bus_req_ready <= (($urandom % 4) != 0);
    if (pend_addr.size() > 0 && pend_due[0] <= cyc + 1) begin
      bus_rsp <= '{valid: 1'b1, data: mem_word(pend_addr[0])};
      pend_addr.delete(0);
      pend_due.delete(0);
    end else begin
      bus_rsp <= '{valid: 1'b0, data: 32'h0};
    end
    // Decode is held off during the jump so nothing from the old path slips through
    if (jump_now) begin
      jump_en     <= 1'b1;
      jump_addr   <= jmp_target[jmp_idx];
      deliv_ready <= 1'b0;
      jmp_idx++;
      jump_now = 1'b0;
    end else begin
      jump_en <= 1'b0;
      if (stall_left > 0) begin
        deliv_ready <= 1'b0;
        stall_left--;
      end else if (($urandom % 6) == 0) begin
        deliv_ready <= 1'b0;
        stall_left = int'($urandom % 5);
      end else begin
        deliv_ready <= 1'b1;
      end
    end
  endtask

  initial begin
    rest          <= 1'b0;
    bus_req_ready <= 1'b0;
    bus_rsp       <= '0;
    jump_en       <= 1'b0;
    jump_addr     <= 32'h0;
    deliv_ready   <= 1'b0;
    cyc = 0;
    n_seen = 0;
    n_checks = 0;
    n_errors = 0;
    test_errors_base = 0;
    jmp_idx = 0;
    idle = 0;
    stall_left = 0;
    jump_now = 1'b0;
    timed_out = 1'b0;
    load_ok = 1'b1;
    seed_dummy = $urandom(87590);
    load_golden();
    bad_golden = !load_ok || (exp_pc.size() == 0);

    repeat (8) @(posedge clk);
    rest <= 1'b1;

    while (!bad_golden && n_seen < exp_pc.size() && !timed_out) begin
      @(negedge clk);
      observe_cycle();
      if (idle > IDLE_LIMIT) begin
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        drive_cycle();
        cyc++;
      end
    end

    asrt_fails = dut0.u_checks.fail_count;
    if (bad_golden) begin
      $display("golden file dv/fetch_golden.txt is missing, empty or malformed");
    end
    if (timed_out) begin
      $display("timeout: no delivery for %0d cycles, %0d of %0d instructions received",
               IDLE_LIMIT, n_seen, exp_pc.size());
    end
    $display("summary: %0d deliveries, %0d checks, %0d errors, %0d assertion failures",
             n_seen, n_checks, n_errors, asrt_fails);
    if (bad_golden || timed_out || n_errors != 0 || asrt_fails != 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

// File: dv/fetch_assertions.sv
`timescale 1ns/1ps

// Protocol checks on the fetch stage ports, bound into fetch_top
module fetch_assertions
  import fetch_bus_pkg::*;
  import fetch_core_pkg::*;
(
  input logic       clk,
  input logic       rest,
  input bus_req_t   bus_req,
  input logic       jump_en,
  input fetch_out_t deliv,
  input logic       deliv_ready
);
  // Number of failed assertions, read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Reads always go out on word boundaries
  req_aligned: assert property (@(posedge clk) disable iff (!rest)
    bus_req.valid |-> (bus_req.addr[1:0] == 2'b00))
    else begin
      $error("bus request address %08h is not word aligned", bus_req.addr);
      fail_count++;
    end

  // A jump drops whatever the delivery register was holding
  jump_clears_valid: assert property (@(posedge clk) disable iff (!rest)
    jump_en |=> !deliv.valid)
    else begin
      $error("delivery valid still high in the cycle after a jump");
      fail_count++;
    end

  // A stalled delivery must not change until decode takes it, unless a jump kills it
  deliv_holds: assert property (@(posedge clk) disable iff (!rest)
    (deliv.valid && !deliv_ready && !jump_en) |=> $stable(deliv))
    else begin
      $error("delivery changed while stalled by deliv_ready");
      fail_count++;
    end

  // Instructions sit on parcel boundaries, so a delivered PC is even
  pc_even: assert property (@(posedge clk) disable iff (!rest)
    deliv.valid |-> !deliv.pc[0])
    else begin
      $error("delivered pc %08h is odd", deliv.pc);
      fail_count++;
    end

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

// Instruction fetch stage with compressed instruction support
module fetch_top
  import fetch_bus_pkg::*;
  import fetch_core_pkg::*;
(
  input  logic        clk,
  input  logic        rest,
  output bus_req_t    bus_req,
  input  logic        bus_req_ready,
  input  bus_rsp_t    bus_rsp,
  input  logic        jump_en,
  input  logic [31:0] jump_addr,
  output fetch_out_t  deliv,
  input  logic        deliv_ready
);
  localparam int WAIT_DEPTH   = `FETCH_WAIT_DEPTH;
  localparam int SHIFT_DEPTH  = `FETCH_SHIFT_DEPTH;
  localparam int PREFETCH_NUM = `FETCH_PREFETCH_NUM;

  // PC and the value it takes on the next edge
  logic [31:0] pc;
  logic [31:0] next_pc;

  // Assembler results
  logic [31:0] instr;
  logic        instr_ok;
  logic [1:0]  urgent_req;

  // Tag FIFO of reads in flight
  logic        fifo_push;
  word_tag_t   fifo_push_tag;
  logic        fifo_full;
  word_tag_t   popped_tag;
  word_tag_t   inflight_tags [WAIT_DEPTH];

  // Shift buffer of returned words
  word_tag_t   buffered_tags  [SHIFT_DEPTH];
  fetch_word_u buffered_words [SHIFT_DEPTH];

  // The response data enters the core as a full word
  fetch_word_u rsp_word;
  assign rsp_word.word = bus_rsp.data;

  // Input side decides the next read and remembers what is outstanding
  prefetch_requester #(
    .WAIT_DEPTH   (WAIT_DEPTH),
    .SHIFT_DEPTH  (SHIFT_DEPTH),
    .PREFETCH_NUM (PREFETCH_NUM)
  ) u_requester (
    .pc            (pc),
    .next_pc       (next_pc),
    .urgent_req    (urgent_req),
    .inflight_tags (inflight_tags),
    .buffered_tags (buffered_tags),
    .fifo_full     (fifo_full),
    .bus_req_ready (bus_req_ready),
    .bus_req       (bus_req),
    .push          (fifo_push),
    .push_tag      (fifo_push_tag)
  );

  // Each response pops the oldest tag, which then labels the arriving word
  read_tag_fifo #(
    .DEPTH (WAIT_DEPTH)
  ) u_tag_fifo (
    .clk      (clk),
    .rest     (rest),
    .push     (fifo_push),
    .push_tag (fifo_push_tag),
    .pop      (bus_rsp.valid),
    .full     (fifo_full),
    .empty    (),
    .head_tag (popped_tag),
    .all_tags (inflight_tags)
  );

  // Processing part keeps recent words and assembles the PC's instruction
  fetch_word_buffer #(
    .DEPTH (SHIFT_DEPTH)
  ) u_word_buffer (
    .clk       (clk),
    .rest      (rest),
    .write     (bus_rsp.valid),
    .tag       (popped_tag),
    .word      (rsp_word),
    .all_tags  (buffered_tags),
    .all_words (buffered_words)
  );

  parcel_assembler #(
    .WAIT_DEPTH  (WAIT_DEPTH),
    .SHIFT_DEPTH (SHIFT_DEPTH)
  ) u_assembler (
    .pc             (pc),
    .buffered_tags  (buffered_tags),
    .buffered_words (buffered_words),
    .inflight_tags  (inflight_tags),
    .arriving_tag   (popped_tag),
    .arriving_word  (rsp_word),
    .instr          (instr),
    .instr_ok       (instr_ok),
    .urgent_req     (urgent_req)
  );

  // Output side steps the PC and registers the delivery
  pc_sequencer #(
    .RESET_ADDR (`FETCH_RESET_ADDR)
  ) u_pc_seq (
    .clk         (clk),
    .rest        (rest),
    .instr       (instr),
    .instr_ok    (instr_ok),
    .jump_en     (jump_en),
    .jump_addr   (jump_addr),
    .deliv_ready (deliv_ready),
    .pc          (pc),
    .next_pc     (next_pc),
    .deliv       (deliv)
  );

endmodule

// File: verilog/pc_sequencer.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

// PC register, next-PC selection and the registered delivery to decode
module pc_sequencer
  import fetch_core_pkg::*;
#(
  parameter logic [31:0] RESET_ADDR = `FETCH_RESET_ADDR
) (
  input  logic        clk,
  input  logic        rest,
  input  logic [31:0] instr,
  input  logic        instr_ok,
  input  logic        jump_en,
  input  logic [31:0] jump_addr,
  input  logic        deliv_ready,
  output logic [31:0] pc,
  output logic [31:0] next_pc,
  output fetch_out_t  deliv
);
  logic [31:0] seq_pc;
  logic        deliv_free;
  logic        advance;
  logic        out_valid;
  logic [31:0] out_instr;
  logic [31:0] out_pc;
  logic [31:0] out_next;

  // Full instructions step by 4, compressed ones by 2
  assign seq_pc = pc + ((instr[1:0] == 2'b11) ? 32'd4 : 32'd2);

  // The register can take a new instruction when empty or being drained
  assign deliv_free = !out_valid || deliv_ready;
  assign advance    = instr_ok && deliv_free;

  // A jump overrides everything, otherwise the PC holds until it can move
  assign next_pc = jump_en ? jump_addr : (advance ? seq_pc : pc);

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      pc <= RESET_ADDR;
    end else begin
      pc <= next_pc;
    end
  end

  // The instruction on the old path is dropped in the cycle of a jump
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      out_valid <= 1'b0;
    end else if (jump_en) begin
      out_valid <= 1'b0;
    end else if (deliv_free) begin
      out_valid <= instr_ok;
    end
  end

  // Payload changes only when a new instruction is accepted
  always_ff @(posedge clk) begin
    if (advance) begin
      out_instr <= instr;
      out_pc    <= pc;
      out_next  <= seq_pc;
    end
  end

  assign deliv = '{instr: out_instr, pc: out_pc, valid: out_valid, next_pc: out_next};

endmodule

// File: verilog/parcel_assembler.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

// Builds the instruction at the PC from 16-bit parcels
module parcel_assembler
  import fetch_core_pkg::*;
#(
  parameter int WAIT_DEPTH  = `FETCH_WAIT_DEPTH,
  parameter int SHIFT_DEPTH = `FETCH_SHIFT_DEPTH
) (
  input  logic [31:0] pc,
  input  word_tag_t   buffered_tags  [SHIFT_DEPTH],
  input  fetch_word_u buffered_words [SHIFT_DEPTH],
  input  word_tag_t   inflight_tags  [WAIT_DEPTH],
  input  word_tag_t   arriving_tag,
  input  fetch_word_u arriving_word,
  output logic [31:0] instr,
  output logic        instr_ok,
  output logic [1:0]  urgent_req
);
  // Candidate 0 is the word arriving now, the rest are the buffered ones
  localparam int NUM_CAND = SHIFT_DEPTH + 1;

  word_tag_t   cand_tags  [NUM_CAND];
  fetch_word_u cand_words [NUM_CAND];
  logic [29:0] need_waddr [2];
  fetch_word_u hit_word   [2];
  logic [1:0]  found;
  logic [1:0]  in_flight;
  logic [15:0] first_parcel;
  logic [15:0] second_parcel;
  logic        is_full;

  always_comb begin
    cand_tags[0]  = arriving_tag;
    cand_words[0] = arriving_word;
    for (int i = 0; i < SHIFT_DEPTH; i++) begin
      cand_tags[i+1]  = buffered_tags[i];
      cand_words[i+1] = buffered_words[i];
    end
  end

  // Word 0 holds the PC, word 1 is the one after it
  assign need_waddr[0] = pc[31:2];
  assign need_waddr[1] = pc[31:2] + 30'd1;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      found[k]     = 1'b0;
      hit_word[k]  = '0;
      in_flight[k] = 1'b0;
      // Scanning from the oldest lets the newest copy of a word win
      for (int c = NUM_CAND - 1; c >= 0; c--) begin
        if (cand_tags[c].valid && (cand_tags[c].waddr == need_waddr[k])) begin
          found[k]    = 1'b1;
          hit_word[k] = cand_words[c];
        end
      end
      for (int j = 0; j < WAIT_DEPTH; j++) begin
        if (inflight_tags[j].valid && (inflight_tags[j].waddr == need_waddr[k])) begin
          in_flight[k] = 1'b1;
        end
      end
    end
  end

  // PC bit 1 selects the half of the word where the instruction starts
  assign first_parcel = pc[1] ? hit_word[0].parcel.hi : hit_word[0].parcel.lo;
  // Low bits of 3 mark a 32-bit instruction, anything else is compressed
  assign is_full      = (first_parcel[1:0] == 2'b11);
  // Upper half comes from the same word, or from the next one when straddling
  assign second_parcel = pc[1] ? hit_word[1].parcel.lo : hit_word[0].parcel.hi;

  assign instr    = is_full ? {second_parcel, first_parcel} : {16'h0000, first_parcel};
  assign instr_ok = found[0] && (!is_full || !pc[1] || found[1]);

  // Ask for a needed word only when nobody has requested it yet
  assign urgent_req[0] = !found[0] && !in_flight[0];
  // The next word is needed only once the PC word shows a straddling instruction
  assign urgent_req[1] = found[0] && is_full && pc[1] && !found[1] && !in_flight[1];

endmodule

// File: verilog/fetch_word_buffer.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

// Shift buffer of the most recently returned words and their addresses
module fetch_word_buffer
  import fetch_core_pkg::*;
#(
  parameter int DEPTH = `FETCH_SHIFT_DEPTH
) (
  input  logic        clk,
  input  logic        rest,
  input  logic        write,
  input  word_tag_t   tag,
  input  fetch_word_u word,
  output word_tag_t   all_tags  [DEPTH],
  output fetch_word_u all_words [DEPTH]
);

  // Newest response enters slot 0 and the oldest drops out of the last slot
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int i = 0; i < DEPTH; i++) begin
        all_tags[i] <= '0;
      end
    end else if (write) begin
      all_tags[0] <= tag;
      for (int i = 1; i < DEPTH; i++) begin
        all_tags[i] <= all_tags[i-1];
      end
    end
  end

  // Each data word shifts along with its tag
  always_ff @(posedge clk) begin
    if (write) begin
      all_words[0] <= word;
      for (int i = 1; i < DEPTH; i++) begin
        all_words[i] <= all_words[i-1];
      end
    end
  end

endmodule

// File: verilog/prefetch_requester.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

// Picks the next word address to read and drives the bus request
module prefetch_requester
  import fetch_bus_pkg::*;
  import fetch_core_pkg::*;
#(
  parameter int WAIT_DEPTH   = `FETCH_WAIT_DEPTH,
  parameter int SHIFT_DEPTH  = `FETCH_SHIFT_DEPTH,
  parameter int PREFETCH_NUM = `FETCH_PREFETCH_NUM
) (
  input  logic [31:0] pc,
  input  logic [31:0] next_pc,
  input  logic [1:0]  urgent_req,
  input  word_tag_t   inflight_tags [WAIT_DEPTH],
  input  word_tag_t   buffered_tags [SHIFT_DEPTH],
  input  logic        fifo_full,
  input  logic        bus_req_ready,
  output bus_req_t    bus_req,
  output logic        push,
  output word_tag_t   push_tag
);
  logic [29:0]             pf_waddr [PREFETCH_NUM];
  logic [PREFETCH_NUM-1:0] pf_known;
  logic [29:0]             req_waddr;
  logic                    req_want;

  // Prefetch window is next_pc's word and the words right after it
  always_comb begin
    for (int i = 0; i < PREFETCH_NUM; i++) begin
      pf_waddr[i] = next_pc[31:2] + 30'(i);
    end
  end

  // A window word is known once it is in flight or sitting in the buffer
  always_comb begin
    for (int i = 0; i < PREFETCH_NUM; i++) begin
      pf_known[i] = 1'b0;
      for (int j = 0; j < WAIT_DEPTH; j++) begin
        if (inflight_tags[j].valid && (inflight_tags[j].waddr == pf_waddr[i])) begin
          pf_known[i] = 1'b1;
        end
      end
      for (int k = 0; k < SHIFT_DEPTH; k++) begin
        if (buffered_tags[k].valid && (buffered_tags[k].waddr == pf_waddr[i])) begin
          pf_known[i] = 1'b1;
        end
      end
    end
  end

  // Urgent words for the current PC win over plain prefetch
  always_comb begin
    req_want  = 1'b0;
    req_waddr = pc[31:2];
    if (urgent_req[0]) begin
      req_want  = 1'b1;
      req_waddr = pc[31:2];
    end else if (urgent_req[1]) begin
      req_want  = 1'b1;
      req_waddr = pc[31:2] + 30'd1;
    end else begin
      // Walking downwards leaves the lowest unknown word selected
      for (int i = PREFETCH_NUM - 1; i >= 0; i--) begin
        if (!pf_known[i]) begin
          req_want  = 1'b1;
          req_waddr = pf_waddr[i];
        end
      end
    end
  end

  // No room for another tag means no request goes out
  assign bus_req.valid = req_want && !fifo_full;
  assign bus_req.addr  = {req_waddr, 2'b00};

  // Tag is recorded only when the bus takes the request
  assign push           = bus_req.valid && bus_req_ready;
  assign push_tag.valid = 1'b1;
  assign push_tag.waddr = req_waddr;

endmodule

// File: verilog/read_tag_fifo.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

// Circular FIFO holding the word address of every accepted read
module read_tag_fifo
  import fetch_core_pkg::*;
#(
  parameter int DEPTH = `FETCH_WAIT_DEPTH
) (
  input  logic      clk,
  input  logic      rest,
  input  logic      push,
  input  word_tag_t push_tag,
  input  logic      pop,
  output logic      full,
  output logic      empty,
  output word_tag_t head_tag,
  output word_tag_t all_tags [DEPTH]
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  word_tag_t        slots [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  // A full FIFO refuses new tags, a pop on an empty one is ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // An accepted push writes its tag into the slot at the write pointer
  always_ff @(posedge clk) begin
    if (do_push) begin
      slots[wr_ptr] <= push_tag;
    end
  end

  // The head tag is valid only in the cycle it is popped by a response
  always_comb begin
    head_tag       = slots[rd_ptr];
    head_tag.valid = slots[rd_ptr].valid && do_pop;
  end

  // Expose every slot so others can see which words are already requested
  always_comb begin
    int off;
    for (int i = 0; i < DEPTH; i++) begin
      // Distance of slot i from the read pointer, wrapped around the ring
      off = i - int'(rd_ptr);
      if (off < 0) begin
        off = off + DEPTH;
      end
      all_tags[i]       = slots[i];
      all_tags[i].valid = slots[i].valid && (off < int'(count));
    end
  end

endmodule

// File: verilog/fetch_core_pkg.sv
// Types used inside the fetch stage and on its delivery port
package fetch_core_pkg;

  // Word address of a read, either in flight or already returned
  // The valid bit marks a slot that holds a real address
  typedef struct packed {
    logic        valid;
    logic [29:0] waddr;
  } word_tag_t;

  // Two 16-bit parcels of one memory word, high half first
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } parcel_pair_t;

  // One returned memory word, seen either as a full word or as two parcels
  typedef union packed {
    logic [31:0]  word;
    parcel_pair_t parcel;
  } fetch_word_u;

  // Instruction handed to decode
  // next_pc is the sequential successor, used by decode as the return address
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        valid;
    logic [31:0] next_pc;
  } fetch_out_t;

endpackage

// File: verilog/fetch_bus_pkg.sv
// Types of the pipelined instruction read bus
package fetch_bus_pkg;

  // Read request, accepted when valid and the bus ready are both high
  // The address is always word aligned
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } bus_req_t;

  // Read response, returned in request order with no back-pressure
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } bus_rsp_t;

endpackage

// File: verilog/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// First PC value once reset is released
`define FETCH_RESET_ADDR 32'h0000_0000

// Number of bus reads that may be accepted and still waiting for data
`define FETCH_WAIT_DEPTH 2

// Number of returned words kept in the shift buffer
`define FETCH_SHIFT_DEPTH 2

// Words counted from the next PC that the requester keeps in flight or buffered
// At least two are needed so a straddling instruction can be completed
`define FETCH_PREFETCH_NUM 2

`endif
